/* rtl/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

	// htrans encodings from the AHB-Lite master
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_e;

	// only byte, half and word are supported
	// wider codes reach the slave and are answered with ERROR
	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_e;

	// address phase as held during the data phase
	// valid is set for NONSEQ and SEQ only
	typedef struct packed {
		logic [31:0] addr;
		logic        write;
		hsize_e      size;
		logic        valid;
	} ahb_addr_phase_t;

endpackage

`default_nettype wire

/* rtl/buf_pkg.sv */
`default_nettype none

package buf_pkg;

	// one posted write towards the sample buffer
	// index is a word index, upper bits are dropped by the buffer
	typedef struct packed {
		logic [31:0] index;
		logic [31:0] data;
		logic [3:0]  strb;
	} buf_wr_t;

	// byte strobes from transfer size and low address bits
	function automatic logic [3:0] lane_strobes(input logic [2:0] size,
		input logic [1:0] addr_lo);
		logic [3:0] strb;
		case (size)
			// byte
			3'b000: strb = 4'b0001 << addr_lo;
			// halfword, bit 0 is known to be clear
			3'b001: strb = addr_lo[1] ? 4'b1100 : 4'b0011;
			default: strb = 4'b1111;
		endcase
		return strb;
	endfunction

endpackage

`default_nettype wire

/* rtl/wr_post_fifo.sv */
`default_nettype none

module wr_post_fifo
	import buf_pkg::*;
#(
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  wire logic    hclk,
	input  wire logic    hrstn,
	input  wire logic    push,
	input  wire buf_wr_t din,
	output logic         full,
	output logic         empty,
	output buf_wr_t      dout,
	output logic         valid
);

	localparam int unsigned PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

	buf_wr_t       entries [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// wrap explicitly, depth need not be a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		return (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full    = (count == CW'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	// buffer always takes the head entry
	assign do_pop  = !empty;
	assign valid   = do_pop;
	assign dout    = entries[rd_ptr];

	always_ff @(posedge hclk) begin
		if (!hrstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge hclk) begin
		if (do_push)
			entries[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

/* rtl/sample_buffer.sv */
`default_nettype none

module sample_buffer
	import buf_pkg::*;
#(
	parameter int unsigned DEPTH = 256
) (
	input  wire logic        hclk,

	input  wire logic        wr_valid,
	input  wire buf_wr_t     wr,

	input  wire logic        rd_en,
	input  wire logic [31:0] rd_index,
	output logic [31:0]      rd_data
);

	localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [31:0]   mem [DEPTH];
	logic          wr_hit;
	logic          rd_hit;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	// indices past the end are dropped here as well
	assign wr_hit  = wr_valid && (wr.index < DEPTH);
	assign rd_hit  = rd_en && (rd_index < DEPTH);
	assign wr_addr = wr.index[AW-1:0];
	assign rd_addr = rd_index[AW-1:0];

	// per-lane update under the strobes
	always_ff @(posedge hclk) begin
		if (wr_hit) begin
			for (int i = 0; i < 4; i++) begin
				if (wr.strb[i])
					mem[wr_addr][8*i +: 8] <= wr.data[8*i +: 8];
			end
		end
	end

	// registered read, holds between strobes
	always_ff @(posedge hclk) begin
		if (rd_hit)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* rtl/ahb_slave_if.sv */
`default_nettype none

module ahb_slave_if
	import ahb_pkg::*;
	import buf_pkg::*;
#(
	parameter int unsigned DEPTH = 256
) (
	input  wire logic        hclk,
	input  wire logic        hrstn,

	input  wire logic [31:0] haddr,
	input  wire htrans_e     htrans,
	input  wire logic        hwrite,
	input  wire hsize_e      hsize,
	input  wire logic [31:0] hwdata,
	// no protection or locking support, both are accepted as is
	input  wire logic [6:0]  hprot,
	input  wire logic        hmastlock,
	output logic [31:0]      hrdata,
	output logic             hready,
	output logic             hresp,

	output logic             wr_push,
	output buf_wr_t          wr_req,
	input  wire logic        wr_full,
	input  wire logic        wr_empty,

	output logic             rd_en,
	output logic [31:0]      rd_index,
	input  wire logic [31:0] rd_data,

	output logic             done,
	output logic             resp
);

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		READ_WAIT,
		READ_DATA,
		ERR1,
		ERR2
	} state_e;

	state_e          state;
	state_e          state_d;
	state_e          next_xfer;
	ahb_addr_phase_t addr_q;
	logic            active;
	logic            misaligned;
	logic            out_of_range;
	logic [3:0]      wr_strb;

	assign active = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

	// address checks on the incoming address phase
	always_comb begin
		case (hsize)
			HSIZE_BYTE: misaligned = 1'b0;
			HSIZE_HALF: misaligned = haddr[0];
			HSIZE_WORD: misaligned = |haddr[1:0];
			default:    misaligned = 1'b1;
		endcase
	end

	assign out_of_range = {2'b00, haddr[31:2]} >= DEPTH;

	// data phase that follows an accepted address phase
	always_comb begin
		if (!active)
			next_xfer = IDLE;
		else if (misaligned || out_of_range)
			next_xfer = ERR1;
		else if (hwrite)
			next_xfer = WRITE;
		else
			next_xfer = READ_WAIT;
	end

	always_comb begin
		hready  = 1'b1;
		hresp   = 1'b0;
		wr_push = 1'b0;
		rd_en   = 1'b0;
		case (state)
			WRITE: begin
				// stall while the queue is full
				hready  = !wr_full;
				wr_push = addr_q.write && !wr_full;
			end
			READ_WAIT: begin
				// posted writes must land before the read
				hready = 1'b0;
				rd_en  = wr_empty;
			end
			ERR1: begin
				hready = 1'b0;
				hresp  = 1'b1;
			end
			ERR2: hresp = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		state_d = state;
		case (state)
			READ_WAIT: begin
				if (wr_empty)
					state_d = READ_DATA;
			end
			ERR1: state_d = ERR2;
			// IDLE, WRITE, READ_DATA and ERR2 take a new address phase
			default: begin
				if (hready)
					state_d = next_xfer;
			end
		endcase
	end

	always_ff @(posedge hclk) begin
		if (!hrstn) begin
			state  <= IDLE;
			addr_q <= '0;
		end else begin
			state <= state_d;
			if (hready) begin
				addr_q.addr  <= haddr;
				addr_q.write <= hwrite;
				addr_q.size  <= hsize;
				addr_q.valid <= active;
			end
		end
	end

	assign wr_strb = lane_strobes(addr_q.size, addr_q.addr[1:0]);

	// sub-word data already sits on its own lanes, unused lanes are cleared
	always_comb begin
		wr_req.index = {2'b00, addr_q.addr[31:2]};
		wr_req.strb  = wr_strb;
		for (int i = 0; i < 4; i++) begin
			wr_req.data[8*i +: 8] = wr_strb[i] ? hwdata[8*i +: 8] : 8'h00;
		end
	end

	assign rd_index = {2'b00, addr_q.addr[31:2]};
	assign hrdata   = rd_data;

	// one pulse per completed data phase
	assign done = hready && addr_q.valid;
	assign resp = (state == ERR2);

endmodule

`default_nettype wire

/* rtl/ahb_buffer_top.sv */
`default_nettype none

module ahb_buffer_top
	import ahb_pkg::*;
	import buf_pkg::*;
#(
	parameter int unsigned DEPTH      = 256,
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  wire logic        hclk,
	input  wire logic        hrstn,

	input  wire logic [31:0] haddr,
	input  wire htrans_e     htrans,
	input  wire logic        hwrite,
	input  wire hsize_e      hsize,
	input  wire logic [31:0] hwdata,
	input  wire logic [6:0]  hprot,
	input  wire logic        hmastlock,
	output logic [31:0]      hrdata,
	output logic             hready,
	output logic             hresp,

	output logic             done,
	output logic             resp
);

	// slave to queue
	logic        wr_push;
	buf_wr_t     wr_req;
	logic        wr_full;
	logic        wr_empty;

	// queue to buffer
	buf_wr_t     fifo_dout;
	logic        fifo_valid;

	// read port
	logic        rd_en;
	logic [31:0] rd_index;
	logic [31:0] rd_data;

	ahb_slave_if #(
		.DEPTH(DEPTH)
	) u_slave (
		.hclk      (hclk),
		.hrstn     (hrstn),
		.haddr     (haddr),
		.htrans    (htrans),
		.hwrite    (hwrite),
		.hsize     (hsize),
		.hwdata    (hwdata),
		.hprot     (hprot),
		.hmastlock (hmastlock),
		.hrdata    (hrdata),
		.hready    (hready),
		.hresp     (hresp),
		.wr_push   (wr_push),
		.wr_req    (wr_req),
		.wr_full   (wr_full),
		.wr_empty  (wr_empty),
		.rd_en     (rd_en),
		.rd_index  (rd_index),
		.rd_data   (rd_data),
		.done      (done),
		.resp      (resp)
	);

	wr_post_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.hclk  (hclk),
		.hrstn (hrstn),
		.push  (wr_push),
		.din   (wr_req),
		.full  (wr_full),
		.empty (wr_empty),
		.dout  (fifo_dout),
		.valid (fifo_valid)
	);

	sample_buffer #(
		.DEPTH(DEPTH)
	) u_buf (
		.hclk     (hclk),
		.wr_valid (fifo_valid),
		.wr       (fifo_dout),
		.rd_en    (rd_en),
		.rd_index (rd_index),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

/* verification/ahb_buffer_sva.sv */
`default_nettype none

module ahb_buffer_sva (
	input wire logic hclk,
	input wire logic hrstn,
	input wire logic hready,
	input wire logic hresp,
	input wire logic done
);

	// first error cycle leads into the second
	a_err_two_cycle: assert property (
		@(posedge hclk) disable iff (!hrstn)
		(hresp && !hready) |=> (hresp && hready)
	) else $error("error response did not finish with hready high");

	a_ready_after_reset: assert property (
		@(posedge hclk) !hrstn |=> hready
	) else $error("hready low right after reset");

	// done marks the end of a data phase
	a_done_with_ready: assert property (
		@(posedge hclk) disable iff (!hrstn)
		done |-> hready
	) else $error("done pulsed while hready was low");

endmodule

bind ahb_buffer_top ahb_buffer_sva u_sva (
	.hclk   (hclk),
	.hrstn  (hrstn),
	.hready (hready),
	.hresp  (hresp),
	.done   (done)
);

`default_nettype wire

/* verification/tb_ahb_buffer.sv */
`default_nettype none

module tb_ahb_buffer
	import ahb_pkg::*;
();

	localparam int DEPTH      = 256;
	localparam int FIFO_DEPTH = 4;
	localparam int AW         = $clog2(DEPTH);
	localparam int N_WORDS    = 40;
	localparam int N_SUB      = 40;
	localparam int N_BP       = FIFO_DEPTH + 4;
	localparam int N_ERR      = 12;
	localparam int N_MIX      = 60;
	// upper bound on transfers including flushes and readbacks
	localparam int N_XFERS = 3 * N_WORDS + 2 * N_SUB + N_BP + 2 * N_ERR + 4 * N_MIX + 8;

	logic        hclk;
	logic        hrstn;
	logic [31:0] haddr;
	htrans_e     htrans;
	logic        hwrite;
	hsize_e      hsize;
	logic [31:0] hwdata;
	logic [6:0]  hprot;
	logic        hmastlock;
	logic [31:0] hrdata;
	logic        hready;
	logic        hresp;
	logic        done;
	logic        resp;

	logic [31:0] model [DEPTH];
	int          idx_list [N_WORDS];
	logic [31:0] lfsr = 32'heceac03b;
	int          errors = 0;
	int          checks = 0;
	int          done_cnt = 0;
	int          issued = 0;
	int          e0, d0, i0;

	// data phase in flight
	logic        p_active = 1'b0;
	logic        p_write = 1'b0;
	logic        p_err = 1'b0;
	logic [31:0] p_addr = '0;
	logic [2:0]  p_size = '0;
	logic [31:0] p_data = '0;

	ahb_buffer_top #(
		.DEPTH      (DEPTH),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_ahb_buffer_top (.*);

	initial begin
		hclk = 1'b0;
		forever #20 hclk = ~hclk;
	end

	always @(negedge hclk) begin
		if (hrstn && done)
			done_cnt <= done_cnt + 1;
	end

	initial begin
		repeat (N_XFERS * 20 + 100) @(posedge hclk);
		$display("timeout: transfers still pending after %0d issued", issued);
		$display("TEST FAILED");
		$finish;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic xfer_error(input logic [31:0] addr, input logic [2:0] size);
		if (size > 3'd2)
			return 1'b1;
		if ((addr & ((32'd1 << size) - 32'd1)) != '0)
			return 1'b1;
		return addr[31:2] >= DEPTH;
	endfunction

	function automatic logic [1:0] align_lo(input logic [1:0] lo, input logic [2:0] size);
		if (size == 3'd0)
			return lo;
		return (size == 3'd1) ? {lo[1], 1'b0} : 2'b00;
	endfunction

	// bytes covered by the transfer take the new data
	function automatic logic [31:0] merge_lanes(input logic [31:0] old,
		input logic [31:0] wdata, input logic [1:0] lo, input logic [2:0] size);
		logic [31:0] res;
		int          nbytes;
		int          first;
		res = old;
		nbytes = 1 << size;
		first = int'(lo) & ~(nbytes - 1);
		for (int b = first; b < first + nbytes; b++)
			res[8*b +: 8] = wdata[8*b +: 8];
		return res;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// new address phase goes out while the previous data phase completes
	task automatic step(input logic [1:0] trans, input logic write, input logic [31:0] addr,
		input logic [2:0] size, input logic [31:0] wdata);
		int stalls;
		stalls = 0;
		htrans <= htrans_e'(trans);
		haddr  <= addr;
		hwrite <= write;
		hsize  <= hsize_e'(size);
		hwdata <= p_data;
		@(negedge hclk);
		while (!hready) begin
			stalls++;
			check_eq(32'(hresp), 32'(p_err), "hresp in wait state");
			@(negedge hclk);
		end
		if (p_active) begin
			check_eq(32'(done), 32'd1, "done");
			check_eq(32'(resp), 32'(p_err), "resp");
			check_eq(32'(hresp), 32'(p_err), "hresp");
			if (p_err)
				check_eq(32'(stalls), 32'd1, "error wait states");
			else if (p_write)
				model[p_addr[AW+1:2]] = merge_lanes(model[p_addr[AW+1:2]], p_data,
					p_addr[1:0], p_size);
			else
				check_eq(hrdata, model[p_addr[AW+1:2]], "read data");
		end else begin
			check_eq(32'(done), 32'd0, "done after idle or busy");
		end
		@(posedge hclk);
		p_active = trans[1];
		p_write  = write;
		p_addr   = addr;
		p_size   = size;
		p_data   = wdata;
		p_err    = trans[1] && xfer_error(addr, size);
		if (trans[1])
			issued++;
	endtask

	task automatic flush();
		step(HTRANS_IDLE, 1'b0, '0, 3'd2, '0);
	endtask

	task automatic start_test();
		e0 = errors;
		d0 = done_cnt;
		i0 = issued;
	endtask

	task automatic report(input string name);
		check_eq(32'(done_cnt - d0), 32'(issued - i0), "done count");
		$display("%s: %0d errors", name, errors - e0);
	endtask

	initial begin
		int         idx;
		logic [1:0] lo;
		logic [2:0] sz;
		logic       wr;
		htrans    <= HTRANS_IDLE;
		haddr     <= '0;
		hwrite    <= 1'b0;
		hsize     <= HSIZE_WORD;
		hwdata    <= '0;
		hprot     <= 7'h03;
		hmastlock <= 1'b0;
		hrstn     <= 1'b0;
		repeat (3) @(posedge hclk);
		hrstn <= 1'b1;

		start_test();
		@(negedge hclk);
		check_eq(32'(hready), 32'd1, "hready after reset");
		check_eq(32'(hresp), 32'd0, "hresp after reset");
		check_eq(32'(done), 32'd0, "done after reset");
		@(posedge hclk);
		report("reset state");

		start_test();
		for (int i = 0; i < N_WORDS; i++) begin
			idx_list[i] = int'(rand_bits(AW));
			step(HTRANS_NONSEQ, 1'b1, 32'(idx_list[i]) << 2, 3'd2, rand_bits(32));
		end
		for (int i = 0; i < N_WORDS; i++)
			step(HTRANS_NONSEQ, 1'b0, 32'(idx_list[i]) << 2, 3'd2, '0);
		flush();
		report("word write and readback");

		start_test();
		for (int i = 0; i < N_SUB; i++) begin
			idx = idx_list[rand_bits(6) % N_WORDS];
			sz = 3'(rand_bits(1));
			lo = align_lo(2'(rand_bits(2)), sz);
			step(rand_bits(1) ? HTRANS_SEQ : HTRANS_NONSEQ, 1'b1, {idx[29:0], lo}, sz,
				rand_bits(32));
			step(HTRANS_NONSEQ, 1'b0, {idx[29:0], 2'b00}, 3'd2, '0);
		end
		flush();
		report("byte and halfword writes");

		// same word written back to back then read right behind
		start_test();
		idx = idx_list[0];
		for (int i = 0; i < N_BP; i++)
			step(i == 0 ? HTRANS_NONSEQ : HTRANS_SEQ, 1'b1, {idx[29:0], 2'b00}, 3'd2,
				rand_bits(32));
		step(HTRANS_NONSEQ, 1'b0, {idx[29:0], 2'b00}, 3'd2, '0);
		flush();
		report("back-pressure and ordering");

		start_test();
		for (int i = 0; i < N_ERR; i++) begin
			idx = idx_list[rand_bits(6) % N_WORDS];
			sz = 3'd1 + 3'(rand_bits(1));
			lo = 2'(rand_bits(2)) | 2'b01;
			if (sz == 3'd2 && rand_bits(1) == 1)
				lo = 2'b10;
			// every third one is past the end of the buffer
			if (i % 3 == 2) begin
				idx = DEPTH + int'(rand_bits(AW));
				sz = 3'd2;
				lo = 2'b00;
			end
			step(HTRANS_NONSEQ, 1'b1, {idx[29:0], lo}, sz, rand_bits(32));
			if (idx < DEPTH)
				step(HTRANS_NONSEQ, 1'b0, {idx[29:0], 2'b00}, 3'd2, '0);
		end
		flush();
		report("error responses");

		start_test();
		for (int i = 0; i < N_MIX; i++) begin
			// gaps aim at live words so a stray write would show up
			for (int g = int'(rand_bits(2)); g > 0; g--) begin
				idx = idx_list[rand_bits(6) % N_WORDS];
				step(rand_bits(1) ? HTRANS_BUSY : HTRANS_IDLE, 1'(rand_bits(1)),
					{idx[29:0], 2'b00}, 3'd2, rand_bits(32));
			end
			idx = idx_list[rand_bits(6) % N_WORDS];
			wr = 1'(rand_bits(1));
			sz = wr ? 3'(rand_bits(2) % 3) : 3'd2;
			lo = align_lo(2'(rand_bits(2)), sz);
			step(rand_bits(1) ? HTRANS_SEQ : HTRANS_NONSEQ, wr, {idx[29:0], lo}, sz,
				rand_bits(32));
		end
		// full readback against the model
		for (int i = 0; i < N_WORDS; i++)
			step(HTRANS_NONSEQ, 1'b0, 32'(idx_list[i]) << 2, 3'd2, '0);
		flush();
		report("idle and busy transfers");

		$display("%0d checks, %0d errors, %0d transfers", checks, errors, issued);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
rtl/ahb_pkg.sv
rtl/buf_pkg.sv
rtl/wr_post_fifo.sv
rtl/sample_buffer.sv
rtl/ahb_slave_if.sv
rtl/ahb_buffer_top.sv
verification/ahb_buffer_sva.sv
verification/tb_ahb_buffer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ahb_buffer
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
